//--- verilog.f
hw/exc_pkg.sv
hw/address_error_checker.sv
hw/exception_controller.sv
hw/cop0_regs.sv
hw/exc_unit_top.sv
verification/exc_unit_tb.sv

//--- Makefile
TOP = exc_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
		--top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF "*** TEST PASSED ***" sim.log || (echo "no pass message in log"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- verification/exc_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exc_unit_tb
    import exc_pkg::*;
();

    localparam int SYNC_STAGES = 2;
    localparam int MAX_CYCLES  = 2000;  // the directed sequence runs a few hundred cycles

    logic        clk = 1'b0;
    logic        rst_n;
    logic        valid, is_load, is_store, trap_taken, overflow, is_cop0, prev_branch;
    logic        cop0_we, eret;
    logic [31:0] pc, mem_addr, cop0_wdata;
    mem_width_t  width;
    exc_chk_t    exc_chk;
    logic [5:0]  hw_int;
    logic [4:0]  cop0_waddr, cop0_raddr;
    logic        exception_happen, any_interrupt;
    exc_code_t   exc_code;
    logic [31:0] exc_addr, epc, cop0_rdata;
    int          errors = 0;
    int          tests_pass = 0;
    int          tests_fail = 0;
    int          cycles = 0;

    exc_unit_top #(.SYNC_STAGES(SYNC_STAGES)) exc_unit_top_inst (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, test sequence did not complete", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ************************************************************
    // stimulus and check tasks
    // ************************************************************
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int mark);
        if (errors == mark) begin
            tests_pass++;
            $display("test %-14s ok", name);
        end else begin
            tests_fail++;
            $display("test %-14s %0d errors", name, errors - mark);
        end
    endtask

    function automatic logic [31:0] rand_pc();
        return $urandom & 32'h7FFF_FFFC;  // aligned, user segment
    endfunction

    task automatic clear_inputs();
        valid       = 1'b0;
        pc          = '0;
        mem_addr    = '0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        width       = WIDTH_WORD;
        exc_chk     = CHK_NONE;
        trap_taken  = 1'b0;
        overflow    = 1'b0;
        is_cop0     = 1'b0;
        prev_branch = 1'b0;
        cop0_we     = 1'b0;
        cop0_waddr  = '0;
        cop0_wdata  = '0;
        eret        = 1'b0;
    endtask

    task automatic idle();
        @(negedge clk);
        clear_inputs();
    endtask

    task automatic issue(input logic [31:0] ipc, input exc_chk_t chk, input logic br);
        idle();
        valid       = 1'b1;
        pc          = ipc;
        exc_chk     = chk;
        prev_branch = br;
    endtask

    // only an interrupt ever reports code 0
    task automatic expect_exc(input logic happen, input exc_code_t code);
        #1;
        check("exception_happen", 32'(exception_happen), 32'(happen));
        check("any_interrupt", 32'(any_interrupt), 32'(happen && code == EXC_INT));
        if (happen) check("exc_code", 32'(exc_code), 32'(code));
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        idle();
        cop0_we    = 1'b1;
        cop0_waddr = addr;
        cop0_wdata = data;
    endtask

    task automatic read_reg(input logic [4:0] addr, input logic [31:0] mask,
                            input logic [31:0] exp, input string name);
        idle();
        cop0_raddr = addr;
        #1;
        check(name, cop0_rdata & mask, exp);
        if (addr == REG_EPC) check("epc", epc & mask, exp);  // eret target port
    endtask

    task automatic do_eret();
        idle();
        eret = 1'b1;
    endtask

    // cause and epc after a commit, then return from the handler
    task automatic check_commit(input exc_code_t code, input logic bd, input logic [31:0] exp_epc);
        read_reg(REG_CAUSE, 32'h8000_007C, {bd, 24'h0, code, 2'b00}, "cause");
        read_reg(REG_EPC, '1, exp_epc, "epc");
        do_eret();
    endtask

    task automatic take_chk(input exc_chk_t chk, input exc_code_t code, input logic br);
        logic [31:0] p;
        p = rand_pc();
        issue(p, chk, br);
        trap_taken = 1'b1;
        overflow   = 1'b1;
        expect_exc(1'b1, code);
        check_commit(code, br, br ? p - 32'd4 : p);
    endtask

    task automatic run_access(input logic [31:0] ipc, input logic [31:0] addr, input logic ld,
                              input logic st, input mem_width_t w, input logic cop,
                              input logic happen, input exc_code_t code, input logic [31:0] bad);
        issue(ipc, CHK_NONE, 1'b0);
        mem_addr = addr;
        is_load  = ld;
        is_store = st;
        width    = w;
        is_cop0  = cop;
        expect_exc(happen, code);
        if (happen) begin
            read_reg(REG_BADVADDR, '1, bad, "badvaddr");
            check_commit(code, 1'b0, ipc);
        end
    endtask

    // ************************************************************
    // test sequence
    // ************************************************************
    initial begin
        int          mark;
        logic [31:0] p, a, w;
        mark = $urandom(32'h8eb3);
        clear_inputs();
        hw_int     = '0;
        cop0_raddr = '0;
        rst_n      = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        mark = errors;
        idle();
        #1;
        check("exc_addr", exc_addr, 32'hBFC0_0380);
        read_reg(REG_STATUS, '1, 32'h0040_0004, "status");
        read_reg(REG_EBASE, '1, 32'h8000_0000, "ebase");
        repeat (3) begin
            idle();
            #1;
            check("exception_happen", 32'(exception_happen), 32'h0);
        end
        finish_test("reset", mark);
        do_eret();  // leave error level

        mark = errors;
        take_chk(CHK_SYSCALL, EXC_SYS, 1'b0);
        take_chk(CHK_BREAK, EXC_BP, 1'b1);
        take_chk(CHK_RESERVED, EXC_RI, 1'b0);
        take_chk(CHK_TRAP, EXC_TR, 1'b1);
        take_chk(CHK_OVERFLOW, EXC_OV, 1'b0);
        issue(rand_pc(), CHK_TRAP, 1'b0);
        expect_exc(1'b0, EXC_INT);
        issue(rand_pc(), CHK_OVERFLOW, 1'b0);
        expect_exc(1'b0, EXC_INT);
        finish_test("instruction", mark);

        mark = errors;
        a = $urandom | 32'h1;
        run_access(rand_pc(), a, 1'b1, 1'b0, WIDTH_HALF, 1'b0, 1'b1, EXC_ADEL, a);
        a = ($urandom & 32'hFFFF_FFFC) | 32'h2;
        run_access(rand_pc(), a, 1'b1, 1'b0, WIDTH_WORD, 1'b0, 1'b1, EXC_ADEL, a);
        a = $urandom | 32'h1;
        run_access(rand_pc(), a, 1'b0, 1'b1, WIDTH_WORD, 1'b0, 1'b1, EXC_ADES, a);
        p = rand_pc() | 32'h2;
        run_access(p, 32'h0, 1'b0, 1'b0, WIDTH_WORD, 1'b0, 1'b1, EXC_ADEL, p);
        p = rand_pc() | 32'h1;
        run_access(p, a, 1'b0, 1'b1, WIDTH_WORD, 1'b0, 1'b1, EXC_ADEL, p);  // fetch wins
        write_reg(REG_STATUS, 32'h0040_0010);   // user mode
        a = ($urandom | 32'h8000_0000) & 32'hFFFF_FFFC;
        run_access(rand_pc(), a, 1'b1, 1'b0, WIDTH_WORD, 1'b1, 1'b1, EXC_ADEL, a);
        finish_test("address", mark);

        mark = errors;
        p = rand_pc();
        issue(p, CHK_SYSCALL, 1'b0);
        is_cop0 = 1'b1;
        expect_exc(1'b1, EXC_CPU);
        check_commit(EXC_CPU, 1'b0, p);
        write_reg(REG_STATUS, 32'h0040_0000);
        run_access(rand_pc(), a, 1'b1, 1'b0, WIDTH_WORD, 1'b1, 1'b0, EXC_INT, 32'h0);
        finish_test("cop_unusable", mark);

        mark = errors;
        idle();
        hw_int = 6'b000001;
        repeat (SYNC_STAGES - 1) read_reg(REG_CAUSE, 32'h0000_FF00, 32'h0, "cause.ip");
        read_reg(REG_CAUSE, 32'h0000_FF00, 32'h0000_0400, "cause.ip");
        write_reg(REG_STATUS, 32'h0040_0001);   // ie without mask
        issue(rand_pc(), CHK_NONE, 1'b0);
        expect_exc(1'b0, EXC_INT);
        write_reg(REG_STATUS, 32'h0040_0405);   // masked in but erl set
        issue(rand_pc(), CHK_NONE, 1'b0);
        expect_exc(1'b0, EXC_INT);
        write_reg(REG_STATUS, 32'h0040_0401);
        issue(rand_pc(), CHK_SYSCALL, 1'b0);
        expect_exc(1'b1, EXC_INT);
        issue(rand_pc(), CHK_NONE, 1'b0);
        expect_exc(1'b0, EXC_INT);  // exl now blocks it
        idle();
        hw_int = '0;
        repeat (SYNC_STAGES) idle();
        do_eret();
        write_reg(REG_CAUSE, 32'h0000_0100);
        write_reg(REG_STATUS, 32'h0040_0101);
        issue(rand_pc(), CHK_NONE, 1'b0);
        expect_exc(1'b1, EXC_INT);
        write_reg(REG_CAUSE, 32'h0);
        do_eret();
        finish_test("interrupt", mark);

        mark = errors;
        p = rand_pc();
        issue(p, CHK_SYSCALL, 1'b1);
        expect_exc(1'b1, EXC_SYS);
        issue(rand_pc(), CHK_BREAK, 1'b0);
        expect_exc(1'b1, EXC_BP);
        read_reg(REG_EPC, '1, p - 32'd4, "epc");
        read_reg(REG_CAUSE, 32'h8000_007C, 32'h8000_0024, "cause");
        read_reg(REG_STATUS, 32'h2, 32'h2, "status.exl");
        do_eret();
        read_reg(REG_STATUS, 32'h2, 32'h0, "status.exl");
        w = $urandom;
        write_reg(REG_EBASE, w);
        write_reg(REG_STATUS, 32'h0);
        idle();
        #1;
        check("exc_addr", exc_addr, {2'b10, w[29:12], 12'h180});
        p = rand_pc();
        issue(p, CHK_SYSCALL, 1'b0);
        cop0_we    = 1'b1;
        cop0_waddr = REG_EPC;
        cop0_wdata = ~p;
        expect_exc(1'b1, EXC_SYS);
        read_reg(REG_EPC, '1, p, "epc");
        do_eret();
        finish_test("nest_vector", mark);

        $display("tests passed %0d, failed %0d", tests_pass, tests_fail);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/exc_unit_top.sv
`default_nettype none
`timescale 1ns/1ps

module exc_unit_top
    import exc_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        valid,
    input  logic [31:0] pc,
    input  logic [31:0] mem_addr,
    input  logic        is_load,
    input  logic        is_store,
    input  mem_width_t  width,
    input  exc_chk_t    exc_chk,
    input  logic        trap_taken,
    input  logic        overflow,
    input  logic        is_cop0,
    input  logic        prev_branch,
    input  logic [5:0]  hw_int,
    input  logic        cop0_we,
    input  logic [4:0]  cop0_waddr,
    input  logic [31:0] cop0_wdata,
    input  logic [4:0]  cop0_raddr,
    input  logic        eret,
    output logic        exception_happen,
    output exc_code_t   exc_code,
    output logic [31:0] exc_addr,
    output logic        any_interrupt,
    output logic [31:0] epc,
    output logic [31:0] cop0_rdata
);

    logic [31:0] status;
    logic [7:0]  cause_ip;
    logic [31:0] ebase;
    logic        fetch_error;
    logic        load_error;
    logic        store_error;
    logic        exc_bd;
    logic [31:0] exc_epc;
    logic        load_badvaddr;
    logic [31:0] badvaddr;

    address_error_checker address_error_checker_inst (
        .pc          (pc),
        .mem_addr    (mem_addr),
        .is_load     (is_load),
        .is_store    (is_store),
        .width       (width),
        .status      (status),
        .fetch_error (fetch_error),
        .load_error  (load_error),
        .store_error (store_error)
    );

    exception_controller exception_controller_inst (
        .valid            (valid),
        .pc               (pc),
        .mem_addr         (mem_addr),
        .exc_chk          (exc_chk),
        .trap_taken       (trap_taken),
        .overflow         (overflow),
        .is_cop0          (is_cop0),
        .prev_branch      (prev_branch),
        .status           (status),
        .cause_ip         (cause_ip),
        .ebase            (ebase),
        .fetch_error      (fetch_error),
        .load_error       (load_error),
        .store_error      (store_error),
        .exception_happen (exception_happen),
        .exc_code         (exc_code),
        .exc_bd           (exc_bd),
        .exc_epc          (exc_epc),
        .load_badvaddr    (load_badvaddr),
        .badvaddr         (badvaddr),
        .exc_addr         (exc_addr),
        .any_interrupt    (any_interrupt)
    );

    cop0_regs #(
        .SYNC_STAGES (SYNC_STAGES)
    ) cop0_regs_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .hw_int           (hw_int),
        .we               (cop0_we),
        .waddr            (cop0_waddr),
        .wdata            (cop0_wdata),
        .raddr            (cop0_raddr),
        .eret             (eret),
        .exception_happen (exception_happen),
        .exc_code         (exc_code),
        .exc_bd           (exc_bd),
        .exc_epc          (exc_epc),
        .load_badvaddr    (load_badvaddr),
        .badvaddr         (badvaddr),
        .rdata            (cop0_rdata),
        .status           (status),
        .cause_ip         (cause_ip),
        .ebase            (ebase),
        .epc              (epc)
    );

endmodule

`default_nettype wire

//--- hw/cop0_regs.sv
`default_nettype none
`timescale 1ns/1ps

module cop0_regs
    import exc_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [5:0]  hw_int,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr,
    input  logic        eret,
    input  logic        exception_happen,
    input  exc_code_t   exc_code,
    input  logic        exc_bd,
    input  logic [31:0] exc_epc,
    input  logic        load_badvaddr,
    input  logic [31:0] badvaddr,
    output logic [31:0] rdata,
    output logic [31:0] status,
    output logic [7:0]  cause_ip,
    output logic [31:0] ebase,
    output logic [31:0] epc
);

    logic [5:0]  int_sync [SYNC_STAGES];
    logic        cause_bd;
    exc_code_t   cause_exc;
    logic [1:0]  soft_ip;
    logic [31:0] badvaddr_q;
    logic [31:0] cause_word;

    // ************************************************************
    // hardware interrupt synchronizer
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                int_sync[i] <= '0;
            end
        end else begin
            int_sync[0] <= hw_int;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                int_sync[i] <= int_sync[i-1];
            end
        end
    end

    assign cause_ip = {int_sync[SYNC_STAGES-1], soft_ip};

    // ************************************************************
    // register update: exception, then eret, then mtc0
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status     <= STATUS_RESET;
            cause_bd   <= 1'b0;
            cause_exc  <= EXC_INT;
            soft_ip    <= '0;
            epc        <= '0;
            badvaddr_q <= '0;
            ebase      <= EBASE_RESET;
        end else if (exception_happen) begin
            cause_exc          <= exc_code;
            status[STATUS_EXL] <= 1'b1;
            if (!status[STATUS_EXL]) begin  // nested: keep original epc
                cause_bd <= exc_bd;
                epc      <= exc_epc;
            end
            if (load_badvaddr) begin
                badvaddr_q <= badvaddr;
            end
        end else if (eret) begin
            if (status[STATUS_ERL]) status[STATUS_ERL] <= 1'b0;
            else                    status[STATUS_EXL] <= 1'b0;
        end else if (we) begin
            case (waddr)
                REG_STATUS: status        <= wdata;
                REG_CAUSE:  soft_ip       <= wdata[CAUSE_IP_S +: 2];  // sw interrupts only
                REG_EPC:    epc           <= wdata;
                REG_EBASE:  ebase[29:12]  <= wdata[29:12];
                default: ;
            endcase
        end
    end

    always_comb begin
        cause_word                     = '0;
        cause_word[CAUSE_BD]           = cause_bd;
        cause_word[CAUSE_IP_S +: 8]    = cause_ip;
        cause_word[CAUSE_EXC_S +: 5]   = cause_exc;
    end

    // mfc0 read port
    always_comb begin
        case (raddr)
            REG_BADVADDR: rdata = badvaddr_q;
            REG_STATUS:   rdata = status;
            REG_CAUSE:    rdata = cause_word;
            REG_EPC:      rdata = epc;
            REG_EBASE:    rdata = ebase;
            default:      rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/exception_controller.sv
`default_nettype none
`timescale 1ns/1ps

module exception_controller
    import exc_pkg::*;
(
    input  logic        valid,
    input  logic [31:0] pc,
    input  logic [31:0] mem_addr,
    input  exc_chk_t    exc_chk,
    input  logic        trap_taken,
    input  logic        overflow,
    input  logic        is_cop0,
    input  logic        prev_branch,
    input  logic [31:0] status,
    input  logic [7:0]  cause_ip,
    input  logic [31:0] ebase,
    input  logic        fetch_error,
    input  logic        load_error,
    input  logic        store_error,
    output logic        exception_happen,
    output exc_code_t   exc_code,
    output logic        exc_bd,
    output logic [31:0] exc_epc,
    output logic        load_badvaddr,
    output logic [31:0] badvaddr,
    output logic [31:0] exc_addr,
    output logic        any_interrupt
);

    logic       kernel_mode;
    logic [7:0] int_masked;

    // ************************************************************
    // interrupt qualification
    // ************************************************************
    assign int_masked    = cause_ip & status[STATUS_IM_E:STATUS_IM_S];
    assign any_interrupt = status[STATUS_IE] & ~status[STATUS_EXL] & ~status[STATUS_ERL]
                         & (|int_masked);

    assign kernel_mode = status[STATUS_ERL] | status[STATUS_EXL] | ~status[STATUS_UM];

    // ************************************************************
    // cause selection by fixed priority
    // ************************************************************
    always_comb begin
        exception_happen = 1'b0;
        exc_code         = EXC_INT;
        load_badvaddr    = 1'b0;
        badvaddr         = '0;

        if (any_interrupt) begin    // taken even on a bubble
            exception_happen = 1'b1;
            exc_code         = EXC_INT;
        end else if (valid) begin
            if (fetch_error) begin
                exception_happen = 1'b1;
                exc_code         = EXC_ADEL;
                load_badvaddr    = 1'b1;
                badvaddr         = pc;
            end else if (load_error) begin
                exception_happen = 1'b1;
                exc_code         = EXC_ADEL;
                load_badvaddr    = 1'b1;
                badvaddr         = mem_addr;
            end else if (store_error) begin
                exception_happen = 1'b1;
                exc_code         = EXC_ADES;
                load_badvaddr    = 1'b1;
                badvaddr         = mem_addr;
            end else if (is_cop0 && !kernel_mode) begin
                exception_happen = 1'b1;
                exc_code         = EXC_CPU;
            end else begin
                case (exc_chk)
                    CHK_SYSCALL: begin
                        exception_happen = 1'b1;
                        exc_code         = EXC_SYS;
                    end
                    CHK_BREAK: begin
                        exception_happen = 1'b1;
                        exc_code         = EXC_BP;
                    end
                    CHK_TRAP: begin
                        exception_happen = trap_taken;  // conditional trap
                        exc_code         = EXC_TR;
                    end
                    CHK_OVERFLOW: begin
                        exception_happen = overflow;
                        exc_code         = EXC_OV;
                    end
                    CHK_RESERVED: begin
                        exception_happen = 1'b1;
                        exc_code         = EXC_RI;
                    end
                    default: begin
                        exception_happen = 1'b0;
                    end
                endcase
            end
        end
    end

    // restart at the branch when in a delay slot
    assign exc_bd  = prev_branch;
    assign exc_epc = prev_branch ? (pc - 32'd4) : pc;

    assign exc_addr = status[STATUS_BEV] ? (BOOT_VECTOR + VECTOR_OFFSET)
                                         : (ebase + VECTOR_OFFSET);

endmodule

`default_nettype wire

//--- hw/address_error_checker.sv
`default_nettype none
`timescale 1ns/1ps

module address_error_checker
    import exc_pkg::*;
(
    input  logic [31:0] pc,
    input  logic [31:0] mem_addr,
    input  logic        is_load,
    input  logic        is_store,
    input  mem_width_t  width,
    input  logic [31:0] status,
    output logic        fetch_error,
    output logic        load_error,
    output logic        store_error
);

    logic kernel_mode;
    logic misaligned;
    logic data_error;

    assign kernel_mode = status[STATUS_ERL] | status[STATUS_EXL] | ~status[STATUS_UM];

    // alignment requirement depends on access width
    always_comb begin
        case (width)
            WIDTH_HALF: misaligned = mem_addr[0];
            WIDTH_WORD: misaligned = |mem_addr[1:0];
            default:    misaligned = 1'b0;
        endcase
    end

    // kseg addresses are off limits in user mode
    assign data_error  = misaligned | (mem_addr[31] & ~kernel_mode);

    assign fetch_error = (|pc[1:0]) | (pc[31] & ~kernel_mode);
    assign load_error  = is_load & data_error;
    assign store_error = is_store & data_error;

endmodule

`default_nettype wire

//--- hw/exc_pkg.sv
`default_nettype none

package exc_pkg;

    // ************************************************************
    // exception codes and check kinds
    // ************************************************************
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,    // address error on load or fetch
        EXC_ADES = 5'd5,    // address error on store
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_CPU  = 5'd11,   // coprocessor unusable
        EXC_OV   = 5'd12,
        EXC_TR   = 5'd13
    } exc_code_t;

    typedef enum logic [2:0] {
        CHK_NONE     = 3'd0,
        CHK_SYSCALL  = 3'd1,
        CHK_BREAK    = 3'd2,
        CHK_TRAP     = 3'd3,
        CHK_OVERFLOW = 3'd4,
        CHK_RESERVED = 3'd5
    } exc_chk_t;

    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'd0,
        WIDTH_HALF = 2'd1,
        WIDTH_WORD = 2'd2
    } mem_width_t;

    // ************************************************************
    // cop0 register map and field positions
    // ************************************************************
    localparam logic [4:0] REG_BADVADDR = 5'd8;
    localparam logic [4:0] REG_STATUS   = 5'd12;
    localparam logic [4:0] REG_CAUSE    = 5'd13;
    localparam logic [4:0] REG_EPC      = 5'd14;
    localparam logic [4:0] REG_EBASE    = 5'd15;

    localparam int STATUS_IE   = 0;
    localparam int STATUS_EXL  = 1;
    localparam int STATUS_ERL  = 2;
    localparam int STATUS_UM   = 4;
    localparam int STATUS_IM_S = 8;
    localparam int STATUS_IM_E = 15;
    localparam int STATUS_BEV  = 22;

    localparam int CAUSE_EXC_S = 2;
    localparam int CAUSE_IP_S  = 8;
    localparam int CAUSE_BD    = 31;

    // boot state: bootstrap vectors, error level set
    localparam logic [31:0] STATUS_RESET  = (32'h1 << STATUS_BEV) | (32'h1 << STATUS_ERL);
    localparam logic [31:0] EBASE_RESET   = 32'h8000_0000;
    localparam logic [31:0] BOOT_VECTOR   = 32'hBFC0_0200;
    localparam logic [31:0] VECTOR_OFFSET = 32'h0000_0180;

endpackage

`default_nettype wire
